/* mips_alu_cfg.svh */
`ifndef MIPS_ALU_CFG_SVH
`define MIPS_ALU_CFG_SVH

// Datapath width of rs, rt, result, HI and LO
`define MIPS_XLEN 32

// Result buffer slots, equal to the upstream credits after reset
`define MIPS_RES_DEPTH 4

// Credits the consumer grants after reset
`define MIPS_OUT_CREDITS 2

`endif

/* mips_alu_pkg.sv */
`default_nettype none

package mips_alu_pkg;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt; // instr[10:6]
		logic [5:0] funct; // instr[5:0]
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm; // instr[15:0]
	} i_fmt_t;

	// One instruction word, seen as either format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

	typedef enum logic [5:0] {
		OP_ADDU,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_SLLV,
		OP_SRLV,
		OP_SRAV,
		OP_SLT,
		OP_SLTU,
		OP_MULT,
		OP_MULTU,
		OP_DIV,
		OP_DIVU,
		OP_MFHI,
		OP_MFLO,
		OP_ADDIU,
		OP_ANDI,
		OP_ORI,
		OP_XORI,
		OP_LUI,
		OP_SLTI,
		OP_SLTIU,
		OP_BEQ,
		OP_BNE,
		OP_LB,
		OP_LH,
		OP_LW,
		OP_LBU,
		OP_LHU,
		OP_SB,
		OP_SH,
		OP_SW,
		OP_ILLEGAL
	} alu_op_e;

	// Second ALU operand
	typedef enum logic [1:0] {
		OPB_RT,
		OPB_SEXT,  // Sign-extended imm
		OPB_ZEXT,  // Zero-extended imm
		OPB_UPPER  // imm in the upper half
	} opb_sel_e;

endpackage

`default_nettype wire

/* mips_decode.sv */
`default_nettype none

module mips_decode (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   in_valid,
	input  logic [31:0]            in_instr,
	input  logic [31:0]            in_rs,
	input  logic [31:0]            in_rt,
	output logic                   dec_valid,
	output mips_alu_pkg::alu_op_e  dec_op,
	output mips_alu_pkg::opb_sel_e dec_opb,
	output logic [31:0]            dec_imm,
	output logic [4:0]             dec_shamt,
	output logic [31:0]            dec_rs,
	output logic [31:0]            dec_rt
);

	// R-type function codes
	localparam logic [5:0] FN_SLL   = 6'h00;
	localparam logic [5:0] FN_SRL   = 6'h02;
	localparam logic [5:0] FN_SRA   = 6'h03;
	localparam logic [5:0] FN_SLLV  = 6'h04;
	localparam logic [5:0] FN_SRLV  = 6'h06;
	localparam logic [5:0] FN_SRAV  = 6'h07;
	localparam logic [5:0] FN_MFHI  = 6'h10;
	localparam logic [5:0] FN_MFLO  = 6'h12;
	localparam logic [5:0] FN_MULT  = 6'h18;
	localparam logic [5:0] FN_MULTU = 6'h19;
	localparam logic [5:0] FN_DIV   = 6'h1a;
	localparam logic [5:0] FN_DIVU  = 6'h1b;
	localparam logic [5:0] FN_ADDU  = 6'h21;
	localparam logic [5:0] FN_SUBU  = 6'h23;
	localparam logic [5:0] FN_AND   = 6'h24;
	localparam logic [5:0] FN_OR    = 6'h25;
	localparam logic [5:0] FN_XOR   = 6'h26;
	localparam logic [5:0] FN_SLT   = 6'h2a;
	localparam logic [5:0] FN_SLTU  = 6'h2b;

	// Opcodes
	localparam logic [5:0] OPC_RTYPE = 6'h00;
	localparam logic [5:0] OPC_BEQ   = 6'h04;
	localparam logic [5:0] OPC_BNE   = 6'h05;
	localparam logic [5:0] OPC_ADDIU = 6'h09;
	localparam logic [5:0] OPC_SLTI  = 6'h0a;
	localparam logic [5:0] OPC_SLTIU = 6'h0b;
	localparam logic [5:0] OPC_ANDI  = 6'h0c;
	localparam logic [5:0] OPC_ORI   = 6'h0d;
	localparam logic [5:0] OPC_XORI  = 6'h0e;
	localparam logic [5:0] OPC_LUI   = 6'h0f;
	localparam logic [5:0] OPC_LB    = 6'h20;
	localparam logic [5:0] OPC_LH    = 6'h21;
	localparam logic [5:0] OPC_LW    = 6'h23;
	localparam logic [5:0] OPC_LBU   = 6'h24;
	localparam logic [5:0] OPC_LHU   = 6'h25;
	localparam logic [5:0] OPC_SB    = 6'h28;
	localparam logic [5:0] OPC_SH    = 6'h29;
	localparam logic [5:0] OPC_SW    = 6'h2b;

	mips_alu_pkg::instr_u   instr;
	mips_alu_pkg::alu_op_e  op_d;
	mips_alu_pkg::opb_sel_e opb_d;

	assign instr = in_instr;

	always_comb begin
		op_d  = mips_alu_pkg::OP_ILLEGAL;
		opb_d = mips_alu_pkg::OPB_RT;
		if (instr.r.opcode == OPC_RTYPE) begin
			case (instr.r.funct)
				FN_SLL:   op_d = mips_alu_pkg::OP_SLL;
				FN_SRL:   op_d = mips_alu_pkg::OP_SRL;
				FN_SRA:   op_d = mips_alu_pkg::OP_SRA;
				FN_SLLV:  op_d = mips_alu_pkg::OP_SLLV;
				FN_SRLV:  op_d = mips_alu_pkg::OP_SRLV;
				FN_SRAV:  op_d = mips_alu_pkg::OP_SRAV;
				FN_MFHI:  op_d = mips_alu_pkg::OP_MFHI;
				FN_MFLO:  op_d = mips_alu_pkg::OP_MFLO;
				FN_MULT:  op_d = mips_alu_pkg::OP_MULT;
				FN_MULTU: op_d = mips_alu_pkg::OP_MULTU;
				FN_DIV:   op_d = mips_alu_pkg::OP_DIV;
				FN_DIVU:  op_d = mips_alu_pkg::OP_DIVU;
				FN_ADDU:  op_d = mips_alu_pkg::OP_ADDU;
				FN_SUBU:  op_d = mips_alu_pkg::OP_SUBU;
				FN_AND:   op_d = mips_alu_pkg::OP_AND;
				FN_OR:    op_d = mips_alu_pkg::OP_OR;
				FN_XOR:   op_d = mips_alu_pkg::OP_XOR;
				FN_SLT:   op_d = mips_alu_pkg::OP_SLT;
				FN_SLTU:  op_d = mips_alu_pkg::OP_SLTU;
				default:  op_d = mips_alu_pkg::OP_ILLEGAL;
			endcase
		end else begin
			opb_d = mips_alu_pkg::OPB_SEXT; // Most I-type ops
			case (instr.i.opcode)
				OPC_BEQ: begin
					op_d  = mips_alu_pkg::OP_BEQ;
					opb_d = mips_alu_pkg::OPB_RT;
				end
				OPC_BNE: begin
					op_d  = mips_alu_pkg::OP_BNE;
					opb_d = mips_alu_pkg::OPB_RT;
				end
				OPC_ADDIU: op_d = mips_alu_pkg::OP_ADDIU;
				OPC_SLTI:  op_d = mips_alu_pkg::OP_SLTI;
				OPC_SLTIU: op_d = mips_alu_pkg::OP_SLTIU; // Unsigned compare with sext imm
				OPC_ANDI: begin
					op_d  = mips_alu_pkg::OP_ANDI;
					opb_d = mips_alu_pkg::OPB_ZEXT;
				end
				OPC_XORI: begin
					op_d  = mips_alu_pkg::OP_XORI;
					opb_d = mips_alu_pkg::OPB_ZEXT;
				end
				OPC_ORI: begin
					op_d  = mips_alu_pkg::OP_ORI;
					opb_d = mips_alu_pkg::OPB_ZEXT;
				end
				OPC_LUI: begin
					op_d  = mips_alu_pkg::OP_LUI;
					opb_d = mips_alu_pkg::OPB_UPPER;
				end
				OPC_LB:  op_d = mips_alu_pkg::OP_LB;
				OPC_LH:  op_d = mips_alu_pkg::OP_LH;
				OPC_LW:  op_d = mips_alu_pkg::OP_LW;
				OPC_LBU: op_d = mips_alu_pkg::OP_LBU;
				OPC_LHU: op_d = mips_alu_pkg::OP_LHU;
				OPC_SB:  op_d = mips_alu_pkg::OP_SB;
				OPC_SH:  op_d = mips_alu_pkg::OP_SH;
				OPC_SW:  op_d = mips_alu_pkg::OP_SW;
				default: op_d = mips_alu_pkg::OP_ILLEGAL;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			dec_op    <= op_d;
			dec_opb   <= opb_d;
			dec_imm   <= {{16{instr.i.imm[15]}}, instr.i.imm}; // Always sign-extended here
			dec_shamt <= instr.r.shamt;
			dec_rs    <= in_rs;
			dec_rt    <= in_rt;
		end
	end

endmodule

`default_nettype wire

/* mips_execute.sv */
`default_nettype none

`include "mips_alu_cfg.svh"

module mips_execute (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   dec_valid,
	input  mips_alu_pkg::alu_op_e  dec_op,
	input  mips_alu_pkg::opb_sel_e dec_opb,
	input  logic [`MIPS_XLEN-1:0]  dec_imm,
	input  logic [4:0]             dec_shamt,
	input  logic [`MIPS_XLEN-1:0]  dec_rs,
	input  logic [`MIPS_XLEN-1:0]  dec_rt,
	output logic                   ex_valid,
	output logic [`MIPS_XLEN-1:0]  ex_result,
	output logic                   ex_branch,
	output logic                   ex_illegal,
	output logic [`MIPS_XLEN-1:0]  ex_hi,
	output logic [`MIPS_XLEN-1:0]  ex_lo
);

	logic [`MIPS_XLEN-1:0]          opb;
	logic [`MIPS_XLEN-1:0]          sum, diff;
	logic                           lt_s, lt_u, eq;
	logic signed [`MIPS_XLEN:0]     mul_a, mul_b;
	logic signed [2*`MIPS_XLEN-1:0] prod;
	logic                           div_signed, rs_neg, rt_neg;
	logic [`MIPS_XLEN-1:0]          div_a, div_b, quot_mag, rem_mag;
	logic [`MIPS_XLEN-1:0]          result_d, hi_d, lo_d;
	logic                           branch_d, illegal_d;

	always_comb begin
		case (dec_opb)
			mips_alu_pkg::OPB_SEXT:  opb = dec_imm;
			mips_alu_pkg::OPB_ZEXT:  opb = {{(`MIPS_XLEN-16){1'b0}}, dec_imm[15:0]};
			mips_alu_pkg::OPB_UPPER: opb = {dec_imm[15:0], {(`MIPS_XLEN-16){1'b0}}};
			default:                 opb = dec_rt;
		endcase
	end

	assign sum  = dec_rs + opb;
	assign diff = dec_rs - opb;
	assign lt_s = $signed(dec_rs) < $signed(opb);
	assign lt_u = dec_rs < opb;
	assign eq   = (dec_rs == dec_rt);

	// One 33x33 signed multiplier serves MULT and MULTU
	assign mul_a = {(dec_op == mips_alu_pkg::OP_MULT) & dec_rs[`MIPS_XLEN-1], dec_rs};
	assign mul_b = {(dec_op == mips_alu_pkg::OP_MULT) & dec_rt[`MIPS_XLEN-1], dec_rt};
	assign prod  = mul_a * mul_b;

	// Unsigned divider on magnitudes, signs fixed afterwards
	assign div_signed = (dec_op == mips_alu_pkg::OP_DIV);
	assign rs_neg     = div_signed & dec_rs[`MIPS_XLEN-1];
	assign rt_neg     = div_signed & dec_rt[`MIPS_XLEN-1];
	assign div_a      = rs_neg ? -dec_rs : dec_rs;
	assign div_b      = rt_neg ? -dec_rt : dec_rt;
	assign quot_mag   = div_a / div_b;
	assign rem_mag    = div_a % div_b;

	always_comb begin
		result_d  = '0;
		branch_d  = 1'b0;
		illegal_d = 1'b0;
		hi_d      = ex_hi; // HI/LO hold unless written
		lo_d      = ex_lo;
		case (dec_op)
			mips_alu_pkg::OP_ADDU, mips_alu_pkg::OP_ADDIU,
			mips_alu_pkg::OP_LB, mips_alu_pkg::OP_LH, mips_alu_pkg::OP_LW,
			mips_alu_pkg::OP_LBU, mips_alu_pkg::OP_LHU,
			mips_alu_pkg::OP_SB, mips_alu_pkg::OP_SH, mips_alu_pkg::OP_SW:
				result_d = sum; // Also load/store address
			mips_alu_pkg::OP_SUBU:                       result_d = diff;
			mips_alu_pkg::OP_AND, mips_alu_pkg::OP_ANDI: result_d = dec_rs & opb;
			mips_alu_pkg::OP_OR, mips_alu_pkg::OP_ORI:   result_d = dec_rs | opb;
			mips_alu_pkg::OP_XOR, mips_alu_pkg::OP_XORI: result_d = dec_rs ^ opb;
			mips_alu_pkg::OP_LUI:                        result_d = opb;
			mips_alu_pkg::OP_SLL:  result_d = dec_rt << dec_shamt;
			mips_alu_pkg::OP_SRL:  result_d = dec_rt >> dec_shamt;
			mips_alu_pkg::OP_SRA:  result_d = $signed(dec_rt) >>> dec_shamt;
			mips_alu_pkg::OP_SLLV: result_d = dec_rt << dec_rs[4:0]; // Low five bits of rs
			mips_alu_pkg::OP_SRLV: result_d = dec_rt >> dec_rs[4:0];
			mips_alu_pkg::OP_SRAV: result_d = $signed(dec_rt) >>> dec_rs[4:0];
			mips_alu_pkg::OP_SLT, mips_alu_pkg::OP_SLTI:
				result_d = {{(`MIPS_XLEN-1){1'b0}}, lt_s};
			mips_alu_pkg::OP_SLTU, mips_alu_pkg::OP_SLTIU:
				result_d = {{(`MIPS_XLEN-1){1'b0}}, lt_u};
			mips_alu_pkg::OP_MULT, mips_alu_pkg::OP_MULTU: begin
				hi_d = prod[2*`MIPS_XLEN-1:`MIPS_XLEN];
				lo_d = prod[`MIPS_XLEN-1:0];
			end
			mips_alu_pkg::OP_DIV, mips_alu_pkg::OP_DIVU: begin
				if (dec_rt == '0) begin
					hi_d = dec_rs; // Divide by zero
					lo_d = '1;
				end else begin
					hi_d = rs_neg ? -rem_mag : rem_mag;
					lo_d = (rs_neg ^ rt_neg) ? -quot_mag : quot_mag;
				end
			end
			mips_alu_pkg::OP_MFHI: result_d = ex_hi;
			mips_alu_pkg::OP_MFLO: result_d = ex_lo;
			mips_alu_pkg::OP_BEQ: begin
				result_d = diff;
				branch_d = eq;
			end
			mips_alu_pkg::OP_BNE: begin
				result_d = diff;
				branch_d = !eq;
			end
			default: illegal_d = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			ex_hi    <= '0;
			ex_lo    <= '0;
		end else begin
			ex_valid <= dec_valid;
			if (dec_valid) begin
				ex_hi <= hi_d;
				ex_lo <= lo_d;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			ex_result  <= result_d;
			ex_branch  <= branch_d;
			ex_illegal <= illegal_d;
		end
	end

endmodule

`default_nettype wire

/* mips_result.sv */
`default_nettype none

`include "mips_alu_cfg.svh"

module mips_result (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  ex_valid,
	input  logic [`MIPS_XLEN-1:0] ex_result,
	input  logic                  ex_branch,
	input  logic                  ex_illegal,
	input  logic [`MIPS_XLEN-1:0] ex_hi,
	input  logic [`MIPS_XLEN-1:0] ex_lo,
	input  logic                  out_credit,
	output logic                  out_valid,
	output logic [`MIPS_XLEN-1:0] out_result,
	output logic                  out_branch,
	output logic                  out_illegal,
	output logic [`MIPS_XLEN-1:0] out_hi,
	output logic [`MIPS_XLEN-1:0] out_lo,
	output logic                  in_credit
);

	logic [3*`MIPS_XLEN+1:0]                 mem [`MIPS_RES_DEPTH];
	logic [$clog2(`MIPS_RES_DEPTH)-1:0]      wr_ptr, rd_ptr; // Power-of-two depth, wrap freely
	logic [$clog2(`MIPS_RES_DEPTH+1)-1:0]    count;
	logic [$clog2(`MIPS_OUT_CREDITS+1)-1:0]  credits;

	// Send whenever an entry waits and the consumer has room
	assign out_valid = (count != '0) && (credits != '0);
	assign in_credit = out_valid; // Freed slot goes back upstream

	assign {out_result, out_branch, out_illegal, out_hi, out_lo} = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			mem[wr_ptr] <= {ex_result, ex_branch, ex_illegal, ex_hi, ex_lo};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (ex_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (out_valid) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({ex_valid, out_valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Downstream credit counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= ($clog2(`MIPS_OUT_CREDITS+1))'(`MIPS_OUT_CREDITS);
		end else begin
			case ({out_credit, out_valid})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits; // Return and spend cancel
			endcase
		end
	end

endmodule

`default_nettype wire

/* mips_alu_top.sv */
`default_nettype none

`include "mips_alu_cfg.svh"

module mips_alu_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  logic [31:0]           in_instr,
	input  logic [`MIPS_XLEN-1:0] in_rs,
	input  logic [`MIPS_XLEN-1:0] in_rt,
	output logic                  in_credit,
	input  logic                  out_credit,
	output logic                  out_valid,
	output logic [`MIPS_XLEN-1:0] out_result,
	output logic                  out_branch,
	output logic                  out_illegal,
	output logic [`MIPS_XLEN-1:0] out_hi,
	output logic [`MIPS_XLEN-1:0] out_lo
);

	// Decode to execute
	logic                   dec_valid;
	mips_alu_pkg::alu_op_e  dec_op;
	mips_alu_pkg::opb_sel_e dec_opb;
	logic [`MIPS_XLEN-1:0]  dec_imm;
	logic [4:0]             dec_shamt;
	logic [`MIPS_XLEN-1:0]  dec_rs;
	logic [`MIPS_XLEN-1:0]  dec_rt;

	// Execute to result buffer
	logic                   ex_valid;
	logic [`MIPS_XLEN-1:0]  ex_result;
	logic                   ex_branch;
	logic                   ex_illegal;
	logic [`MIPS_XLEN-1:0]  ex_hi;
	logic [`MIPS_XLEN-1:0]  ex_lo;

	mips_decode mips_decode_inst (.*);

	mips_execute mips_execute_inst (.*);

	mips_result mips_result_inst (.*);

endmodule

`default_nettype wire

/* mips_alu_tb.sv */
`default_nettype none

`include "mips_alu_cfg.svh"

module mips_alu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic                  clk = 1'b0;
	logic                  arst_n;
	logic                  in_valid;
	logic [31:0]           in_instr;
	logic [`MIPS_XLEN-1:0] in_rs, in_rt;
	logic                  in_credit;
	logic                  out_credit = 1'b0;
	logic                  out_valid;
	logic [`MIPS_XLEN-1:0] out_result, out_hi, out_lo;
	logic                  out_branch, out_illegal;

	// Expected results in issue order
	logic [`MIPS_XLEN-1:0] exp_res_q [$], exp_hi_q [$], exp_lo_q [$];
	logic                  exp_br_q [$], exp_ill_q [$];
	string                 name_q [$];
	logic [`MIPS_XLEN-1:0] model_hi = '0, model_lo = '0;
	logic [31:0]           stim_seed = 32'd64;
	logic [31:0]           dly_seed = 32'd64;
	logic                  hold_credits = 1'b0;
	int                    up_issued = 0, up_returned = 0, rx_count = 0;
	int                    cons_credits = `MIPS_OUT_CREDITS; // Mirror of the DUT credit counter
	int                    value_errors = 0, proto_errors = 0, credit_errors = 0;
	int                    flow_errors = 0, timeout_errors = 0;

	mips_alu_top mips_alu_top_inst (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		stim_seed = xorshift32(stim_seed);
		return stim_seed;
	endfunction

	function automatic mips_alu_pkg::instr_u r_instr(input logic [5:0] funct,
			input logic [4:0] shamt);
		mips_alu_pkg::instr_u u;
		u.r.opcode = 6'h00;
		u.r.rs     = 5'd1;
		u.r.rt     = 5'd2;
		u.r.rd     = 5'd3;
		u.r.shamt  = shamt;
		u.r.funct  = funct;
		return u;
	endfunction

	function automatic mips_alu_pkg::instr_u i_instr(input logic [5:0] opcode,
			input logic [15:0] imm);
		mips_alu_pkg::instr_u u;
		u.i.opcode = opcode;
		u.i.rs     = 5'd1;
		u.i.rt     = 5'd2;
		u.i.imm    = imm;
		return u;
	endfunction

	function automatic void mips_ref(input mips_alu_pkg::instr_u ins,
			input logic [31:0] rs, input logic [31:0] rt,
			input logic [31:0] hi, input logic [31:0] lo,
			output logic [31:0] res, output logic [31:0] new_hi, output logic [31:0] new_lo,
			output logic br, output logic ill);
		logic [31:0]        sext, zext;
		logic [63:0]        tmp;
		logic signed [63:0] a64, b64;
		sext   = {{16{ins.i.imm[15]}}, ins.i.imm};
		zext   = {16'h0000, ins.i.imm};
		a64    = {{32{rs[31]}}, rs}; // Wide signed divide cannot overflow
		b64    = {{32{rt[31]}}, rt};
		res    = '0;
		new_hi = hi;
		new_lo = lo;
		br     = 1'b0;
		ill    = 1'b0;
		if (ins.r.opcode == 6'h00) begin
			case (ins.r.funct)
				6'h00: res = rt << ins.r.shamt;
				6'h02: res = rt >> ins.r.shamt;
				6'h03: res = $signed(rt) >>> ins.r.shamt;
				6'h04: res = rt << rs[4:0];
				6'h06: res = rt >> rs[4:0];
				6'h07: res = $signed(rt) >>> rs[4:0];
				6'h10: res = hi;
				6'h12: res = lo;
				6'h18: {new_hi, new_lo} = a64 * b64;
				6'h19: {new_hi, new_lo} = {32'h0, rs} * {32'h0, rt};
				6'h1a, 6'h1b: begin
					if (rt == '0) begin
						new_hi = rs;
						new_lo = '1;
					end else if (ins.r.funct == 6'h1a) begin
						tmp    = a64 / b64;
						new_lo = tmp[31:0];
						tmp    = a64 % b64;
						new_hi = tmp[31:0];
					end else begin
						new_lo = rs / rt;
						new_hi = rs % rt;
					end
				end
				6'h21: res = rs + rt;
				6'h23: res = rs - rt;
				6'h24: res = rs & rt;
				6'h25: res = rs | rt;
				6'h26: res = rs ^ rt;
				6'h2a: res = {31'h0, $signed(rs) < $signed(rt)};
				6'h2b: res = {31'h0, rs < rt};
				default: ill = 1'b1;
			endcase
		end else begin
			case (ins.i.opcode)
				6'h04, 6'h05: begin
					res = rs - rt; // Every branch gives the difference
					br  = (ins.i.opcode == 6'h04) ? (rs == rt) : (rs != rt);
				end
				6'h09, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b:
					res = rs + sext;
				6'h0a: res = {31'h0, $signed(rs) < $signed(sext)};
				6'h0b: res = {31'h0, rs < sext};
				6'h0c: res = rs & zext;
				6'h0d: res = rs | zext;
				6'h0e: res = rs ^ zext;
				6'h0f: res = {ins.i.imm, 16'h0000};
				default: ill = 1'b1;
			endcase
		end
	endfunction

	function automatic int up_avail();
		return `MIPS_RES_DEPTH - up_issued + up_returned;
	endfunction

	task automatic check_word(input string name, input logic [`MIPS_XLEN-1:0] exp,
			input logic [`MIPS_XLEN-1:0] act);
		if (act !== exp) begin
			value_errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic drive_item(input string name, input mips_alu_pkg::instr_u ins,
			input logic [31:0] rs, input logic [31:0] rt);
		logic [31:0] res, nhi, nlo;
		logic        br, ill;
		in_valid <= 1'b1;
		in_instr <= ins;
		in_rs    <= rs;
		in_rt    <= rt;
		up_issued++;
		mips_ref(ins, rs, rt, model_hi, model_lo, res, nhi, nlo, br, ill);
		model_hi = nhi;
		model_lo = nlo;
		exp_res_q.push_back(res);
		exp_hi_q.push_back(nhi);
		exp_lo_q.push_back(nlo);
		exp_br_q.push_back(br);
		exp_ill_q.push_back(ill);
		name_q.push_back(name);
	endtask

	task automatic issue(input string name, input mips_alu_pkg::instr_u ins,
			input logic [31:0] rs, input logic [31:0] rt);
		int waited;
		waited = 0;
		@(posedge clk);
		while (up_avail() <= 0 && waited < 100) begin
			in_valid <= 1'b0;
			@(posedge clk);
			waited++;
		end
		if (up_avail() <= 0) begin
			timeout_errors++;
			$display("Timeout: no upstream credit came back before %s", name);
			in_valid <= 1'b0;
		end else begin
			drive_item(name, ins, rs, rt);
		end
	endtask

	task automatic wait_drained(input string phase);
		int waited;
		waited = 0;
		@(posedge clk);
		in_valid <= 1'b0;
		while ((rx_count != up_issued || cons_credits != `MIPS_OUT_CREDITS) &&
				waited < 400) begin
			@(posedge clk);
			waited++;
		end
		if (rx_count != up_issued || cons_credits != `MIPS_OUT_CREDITS) begin
			timeout_errors++;
			$display("Timeout: results of the %s phase did not all arrive", phase);
		end
	endtask

	always @(posedge clk) begin
		if (in_credit) begin
			up_returned <= up_returned + 1;
		end
	end

	// Consumer returns each credit after a random delay unless held
	always @(posedge clk) begin : consumer
		int owed;
		owed = `MIPS_OUT_CREDITS - cons_credits - (out_credit ? 1 : 0) + (out_valid ? 1 : 0);
		if (out_valid && cons_credits == 0) begin
			credit_errors++;
			$display("A result was sent while the consumer had granted no credit");
		end
		cons_credits <= cons_credits + (out_credit ? 1 : 0) - (out_valid ? 1 : 0);
		if (!hold_credits && owed > 0 && dly_seed[0]) begin
			out_credit <= 1'b1;
		end else begin
			out_credit <= 1'b0;
		end
		dly_seed = xorshift32(dly_seed);
	end

	always @(posedge clk) begin : compare_results
		string name;
		if (arst_n) begin
			if (in_credit !== out_valid) begin
				proto_errors++;
				$display("An in_credit pulse does not line up with a result");
			end
			if (out_valid) begin
				if (name_q.size() == 0) begin
					proto_errors++;
					$display("A result arrived with nothing expected");
				end else begin
					name = name_q.pop_front();
					check_word({name, " result"}, exp_res_q.pop_front(), out_result);
					check_flag({name, " branch"}, exp_br_q.pop_front(), out_branch);
					check_flag({name, " illegal"}, exp_ill_q.pop_front(), out_illegal);
					check_word({name, " hi"}, exp_hi_q.pop_front(), out_hi);
					check_word({name, " lo"}, exp_lo_q.pop_front(), out_lo);
				end
				rx_count <= rx_count + 1;
			end
		end
	end

	initial begin
		logic [5:0]            r_fns [13];
		logic [5:0]            i_ops [15];
		logic [5:0]            md_fns [4];
		logic [`MIPS_XLEN-1:0] div_a [5];
		logic [`MIPS_XLEN-1:0] div_b [5];
		logic [`MIPS_XLEN-1:0] a, b;
		logic [15:0]           imm;
		logic [4:0]            shamt;
		int                    k, n, rx_before, issued_before, total;
		r_fns  = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06,
			6'h07, 6'h2a, 6'h2b};
		i_ops  = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h21, 6'h23,
			6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
		md_fns = '{6'h18, 6'h19, 6'h1a, 6'h1b};
		div_a  = '{32'hffff_fff9, 32'h0000_0007, 32'hffff_ffff, 32'h0000_007b, 32'h8000_0000};
		div_b  = '{32'h0000_0003, 32'hffff_fffd, 32'h0000_0002, 32'h0000_0000, 32'h7fff_ffff};
		arst_n   = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		in_rs    = '0;
		in_rt    = '0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		for (k = 0; k < 13; k++) begin
			for (n = 0; n < 6; n++) begin
				a     = next_rand(); // Upper rs bits must not affect variable shifts
				b     = next_rand();
				shamt = (n == 0) ? 5'd0 : ((n == 1) ? 5'd31 : b[4:0]);
				if (n < 2) begin
					a[4:0] = shamt; // Variable shifts also by 0 and 31
				end
				issue($sformatf("rtype %h/%0d", r_fns[k], n), r_instr(r_fns[k], shamt), a, b);
			end
		end
		issue("srav low five bits", r_instr(6'h07, 5'd0), 32'hffff_ffe4, 32'h8000_0000);
		wait_drained("R-type");

		for (k = 0; k < 15; k++) begin
			for (n = 0; n < 4; n++) begin
				a   = next_rand();
				b   = next_rand();
				imm = (n == 0) ? 16'h8000 : ((n == 1) ? 16'h7fff : b[31:16]);
				issue($sformatf("itype %h/%0d", i_ops[k], n), i_instr(i_ops[k], imm), a, b);
			end
		end
		issue("slti minus one", i_instr(6'h0a, 16'hffff), 32'h1, 32'h0);
		issue("sltiu minus one", i_instr(6'h0b, 16'hffff), 32'h1, 32'h0);
		issue("slti plus one", i_instr(6'h0a, 16'h0001), 32'hffff_fffe, 32'h0);
		issue("sltiu plus one", i_instr(6'h0b, 16'h0001), 32'hffff_fffe, 32'h0);
		wait_drained("I-type");

		a = next_rand();
		issue("beq equal", i_instr(6'h04, 16'h0010), a, a);
		issue("beq unequal", i_instr(6'h04, 16'h0010), a, a ^ 32'h1);
		issue("bne equal", i_instr(6'h05, 16'hfff0), a, a);
		issue("bne unequal", i_instr(6'h05, 16'hfff0), a, ~a);
		wait_drained("branch");

		for (k = 0; k < 5; k++) begin
			for (n = 0; n < 4; n++) begin
				issue($sformatf("muldiv %h/%0d", md_fns[n], k), r_instr(md_fns[n], 5'd0),
					div_a[k], div_b[k]);
				issue("mfhi", r_instr(6'h10, 5'd0), 32'h0, 32'h0);
				issue("mflo", r_instr(6'h12, 5'd0), 32'h0, 32'h0);
			end
		end
		wait_drained("multiply and divide");

		// HI/LO must survive the illegal words
		issue("mult before illegal", r_instr(6'h18, 5'd0), 32'h0000_0007, 32'hffff_fff7);
		issue("illegal opcode 3f", i_instr(6'h3f, 16'h1234), a, b);
		issue("illegal opcode 13", i_instr(6'h13, 16'h1234), a, b);
		issue("illegal funct 3f", r_instr(6'h3f, 5'd3), a, b);
		issue("illegal funct 01", r_instr(6'h01, 5'd3), a, b);
		issue("mfhi after illegal", r_instr(6'h10, 5'd0), 32'h0, 32'h0);
		issue("mflo after illegal", r_instr(6'h12, 5'd0), 32'h0, 32'h0);
		wait_drained("illegal");

		hold_credits  <= 1'b1;
		rx_before     = rx_count;
		issued_before = up_issued;
		for (n = 0; n < 40; n++) begin
			@(posedge clk);
			if (up_avail() > 0) begin
				drive_item($sformatf("held addu %0d", n), r_instr(6'h21, 5'd0),
					next_rand(), 32'h5);
			end else begin
				in_valid <= 1'b0;
			end
		end
		if (rx_count - rx_before != `MIPS_OUT_CREDITS) begin
			flow_errors++;
			$display("%0d results appeared while downstream credits were withheld",
				rx_count - rx_before);
		end
		if (up_issued - issued_before - (rx_count - rx_before) != `MIPS_RES_DEPTH ||
				up_avail() != 0) begin
			flow_errors++;
			$display("Upstream was not stopped with the result buffer full");
		end
		hold_credits <= 1'b0;
		wait_drained("credit release");

		if (name_q.size() != 0) begin
			flow_errors++;
			$display("%0d expected results never arrived", name_q.size());
		end
		if (up_returned != rx_count) begin
			flow_errors++;
			$display("%0d upstream credits came back for %0d results", up_returned, rx_count);
		end
		total = value_errors + proto_errors + credit_errors + flow_errors + timeout_errors;
		$display("Errors: value %0d, protocol %0d, credit %0d, flow %0d, timeout %0d",
			value_errors, proto_errors, credit_errors, flow_errors, timeout_errors);
		if (total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
mips_alu_pkg.sv
mips_decode.sv
mips_execute.sv
mips_result.sv
mips_alu_top.sv
mips_alu_tb.sv

/* Makefile */
TOP = mips_alu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module mips_alu_top
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
